//--- hw/gf_pkg.sv
package gf_pkg;

  // element of GF(4), polynomial basis.
  localparam int GF4_W = 2;

  // the S-box works on three GF(4) coordinates.
  localparam int SBOX_W = 6;

  typedef logic [GF4_W-1:0] gf4_t;

  typedef logic [SBOX_W-1:0] sbox_t; // one S-box input or output.

endpackage

//--- hw/spn_pkg.sv
package spn_pkg;

  localparam int BLOCK_W = 36; // block and key.
  localparam int N_SBOX = 6;   // S-boxes per round.
  localparam int ROUND_W = 4;  // up to 15 rounds.
  localparam int KEY_ROT = 6;  // left rotation per round.

  // round controller.
  typedef enum logic [1:0] {
    ST_IDLE = 2'd0,
    ST_RUN  = 2'd1,
    ST_DONE = 2'd2
  } spn_state_e;

  // command opcodes on the top-level strobe.
  typedef enum logic [1:0] {
    OP_KEY      = 2'd0,
    OP_ROUNDS   = 2'd1,
    OP_START    = 2'd2,
    OP_READ_KEY = 2'd3
  } spn_op_e;

endpackage

//--- hw/spn_cfg_if.sv
`timescale 1ns/100ps

interface spn_cfg_if;

  logic [spn_pkg::BLOCK_W-1:0] key;
  logic [spn_pkg::ROUND_W-1:0] rounds;
  logic [spn_pkg::BLOCK_W-1:0] block; // plaintext, valid with start.
  logic                        start; // one cycle.
  logic                        busy;
  logic                        done;  // one cycle.

  modport cfg (
    output key, rounds, block, start,
    input  busy, done
  );

  modport eng (
    input  key, rounds, block, start,
    output busy, done
  );

endinterface

//--- hw/sbox6.sv
`timescale 1ns/100ps

module sbox6 (
  input  gf_pkg::sbox_t x,
  output gf_pkg::sbox_t y
);

  function automatic gf_pkg::gf4_t gf4_sq(input gf_pkg::gf4_t a);
    return {a[1], a[1] ^ a[0]};
  endfunction

  function automatic gf_pkg::gf4_t gf4_mul(input gf_pkg::gf4_t a, input gf_pkg::gf4_t b);
    logic t;
    t = a[1] & b[1];
    return {(a[0] & b[1]) ^ (a[1] & b[0]) ^ t, (a[0] & b[0]) ^ t};
  endfunction

  // a cubed is one for any nonzero a in GF(4).
  function automatic gf_pkg::gf4_t gf4_cube_scale(input gf_pkg::gf4_t a,
                                                  input gf_pkg::gf4_t b);
    return (a != '0) ? b : '0;
  endfunction

  gf_pkg::sbox_t z; // tower field coordinates.
  gf_pkg::sbox_t w; // power 13, tower basis.
  gf_pkg::sbox_t p;
  gf_pkg::gf4_t  a0;
  gf_pkg::gf4_t  a1;
  gf_pkg::gf4_t  a2;
  gf_pkg::gf4_t  s0;
  gf_pkg::gf4_t  s1;
  gf_pkg::gf4_t  s2;
  gf_pkg::gf4_t  c01;
  gf_pkg::gf4_t  c02;
  gf_pkg::gf4_t  c10;
  gf_pkg::gf4_t  c12;
  gf_pkg::gf4_t  c20;
  gf_pkg::gf4_t  c21;
  gf_pkg::gf4_t  q01;
  gf_pkg::gf4_t  q02;
  gf_pkg::gf4_t  q12;
  gf_pkg::gf4_t  t0;
  gf_pkg::gf4_t  t1;
  gf_pkg::gf4_t  t2;

  // basis change, one row per output bit.
  assign z[0] = ^(x & 6'b100111);
  assign z[1] = ^(x & 6'b101110);
  assign z[2] = ^(x & 6'b110101);
  assign z[3] = ^(x & 6'b110110);
  assign z[4] = ^(x & 6'b100001);
  assign z[5] = ^(x & 6'b010000);

  assign a0 = z[1:0];
  assign a1 = z[3:2];
  assign a2 = z[5:4];

  assign s0 = gf4_sq(a0);
  assign s1 = gf4_sq(a1);
  assign s2 = gf4_sq(a2);

  assign c01 = gf4_cube_scale(a0, a1);
  assign c02 = gf4_cube_scale(a0, a2);
  assign c10 = gf4_cube_scale(a1, a0);
  assign c12 = gf4_cube_scale(a1, a2);
  assign c20 = gf4_cube_scale(a2, a0);
  assign c21 = gf4_cube_scale(a2, a1);

  assign q01 = gf4_mul(s0, s1);
  assign q02 = gf4_mul(s0, s2);
  assign q12 = gf4_mul(s1, s2);

  // square of one coordinate times the product of the other two.
  assign t0 = gf4_mul(s0, gf4_mul(a1, a2));
  assign t1 = gf4_mul(s1, gf4_mul(a0, a2));
  assign t2 = gf4_mul(s2, gf4_mul(a0, a1));

  assign w[1:0] = a0 ^ a1 ^ c10 ^ c12 ^ c20 ^ q01 ^ q02 ^ t0 ^ t2;
  assign w[3:2] = a1 ^ a2 ^ c01 ^ c20 ^ c21 ^ q01 ^ q12 ^ t0 ^ t1;
  assign w[5:4] = a0 ^ a2 ^ c01 ^ c02 ^ c12 ^ q02 ^ q12 ^ t1 ^ t2;

  // back to the polynomial basis.
  assign p[0] = ^(w & 6'b010100);
  assign p[1] = ^(w & 6'b010110);
  assign p[2] = ^(w & 6'b000001);
  assign p[3] = ^(w & 6'b011000);
  assign p[4] = ^(w & 6'b110011);
  assign p[5] = ^(w & 6'b011011);

  assign y = p ^ {gf_pkg::SBOX_W{x[2] ^ x[4]}}; // parity mask keeps zero at zero.

endmodule

//--- hw/spn_round.sv
`timescale 1ns/100ps

module spn_round (
  input  logic [spn_pkg::BLOCK_W-1:0] state,
  input  logic [spn_pkg::BLOCK_W-1:0] round_key,
  output logic [spn_pkg::BLOCK_W-1:0] next_state
);

  logic [spn_pkg::BLOCK_W-1:0] sub;
  logic [spn_pkg::BLOCK_W-1:0] perm;

  // substitution layer.
  for (genvar i = 0; i < spn_pkg::N_SBOX; i++) begin : g_sbox
    sbox6 u_sbox (
      .x(state[i*gf_pkg::SBOX_W +: gf_pkg::SBOX_W]),
      .y(sub[i*gf_pkg::SBOX_W +: gf_pkg::SBOX_W])
    );
  end

  // bit j of sbox i lands on bit i of group j.
  for (genvar i = 0; i < spn_pkg::N_SBOX; i++) begin : g_perm_i
    for (genvar j = 0; j < gf_pkg::SBOX_W; j++) begin : g_perm_j
      assign perm[j*spn_pkg::N_SBOX + i] = sub[i*gf_pkg::SBOX_W + j];
    end
  end

  assign next_state = perm ^ round_key;

endmodule

//--- hw/spn_regs.sv
`timescale 1ns/100ps

module spn_regs (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cmd_valid,
  input  spn_pkg::spn_op_e            cmd_op,
  input  logic [spn_pkg::BLOCK_W-1:0] cmd_data,
  output logic [spn_pkg::BLOCK_W-1:0] rd_data,
  spn_cfg_if.cfg                      cfg
);

  logic [spn_pkg::BLOCK_W-1:0] key_q;
  logic [spn_pkg::ROUND_W-1:0] rounds_q;
  logic [spn_pkg::BLOCK_W-1:0] block_q;
  logic                        start_q;
  logic                        start_ok;

  // a start while the engine runs is dropped.
  assign start_ok = cmd_valid && (cmd_op == spn_pkg::OP_START) && !cfg.busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      key_q <= '0;
      rounds_q <= '0;
      start_q <= 1'b0;
      rd_data <= '0;
    end else begin
      start_q <= start_ok;
      if (cmd_valid) begin
        case (cmd_op)
          spn_pkg::OP_KEY:      key_q <= cmd_data;
          spn_pkg::OP_ROUNDS:   rounds_q <= cmd_data[spn_pkg::ROUND_W-1:0];
          spn_pkg::OP_READ_KEY: rd_data <= key_q;
          default:              ; // start handled above.
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start_ok) begin
      block_q <= cmd_data; // plaintext.
    end
  end

  assign cfg.key = key_q;
  assign cfg.rounds = rounds_q;
  assign cfg.block = block_q;
  assign cfg.start = start_q;

endmodule

//--- hw/spn_ctrl.sv
`timescale 1ns/100ps

module spn_ctrl (
  input  logic                        clk,
  input  logic                        rst,
  spn_cfg_if.eng                      eng,
  output logic [spn_pkg::BLOCK_W-1:0] state,
  output logic [spn_pkg::BLOCK_W-1:0] round_key,
  input  logic [spn_pkg::BLOCK_W-1:0] next_state,
  output logic [spn_pkg::BLOCK_W-1:0] block_out,
  output logic                        busy_out,
  output logic                        done_out
);

  spn_pkg::spn_state_e         st_q;
  logic [spn_pkg::BLOCK_W-1:0] state_q;
  logic [spn_pkg::BLOCK_W-1:0] key_q;   // running key, copied at start.
  logic [spn_pkg::ROUND_W-1:0] cnt_q;
  logic [spn_pkg::ROUND_W-1:0] rounds_q;
  logic                        last_round;

  assign round_key = {key_q[spn_pkg::BLOCK_W-spn_pkg::KEY_ROT-1:0],
                      key_q[spn_pkg::BLOCK_W-1 -: spn_pkg::KEY_ROT]};
  assign last_round = (cnt_q + 1'b1) == rounds_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      st_q <= spn_pkg::ST_IDLE;
      state_q <= '0;
      cnt_q <= '0;
      rounds_q <= '0;
    end else begin
      case (st_q)
        spn_pkg::ST_RUN: begin
          state_q <= next_state;
          cnt_q <= cnt_q + 1'b1;
          if (last_round) st_q <= spn_pkg::ST_DONE;
        end
        default: begin // idle or done, both take a new start.
          if (eng.start) begin
            state_q <= eng.block ^ eng.key; // whitening.
            cnt_q <= '0;
            rounds_q <= eng.rounds;
            st_q <= (eng.rounds == '0) ? spn_pkg::ST_DONE : spn_pkg::ST_RUN;
          end else begin
            st_q <= spn_pkg::ST_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (st_q == spn_pkg::ST_RUN) begin
      key_q <= round_key;
    end else if (eng.start) begin
      key_q <= eng.key;
    end
  end

  assign state = state_q;
  assign block_out = state_q; // holds until the next start.
  assign busy_out = (st_q == spn_pkg::ST_RUN);
  assign done_out = (st_q == spn_pkg::ST_DONE);
  assign eng.busy = busy_out;
  assign eng.done = done_out;

endmodule

//--- hw/spn_top.sv
`timescale 1ns/100ps

module spn_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        cmd_valid,
  input  spn_pkg::spn_op_e            cmd_op,
  input  logic [spn_pkg::BLOCK_W-1:0] cmd_data,
  output logic [spn_pkg::BLOCK_W-1:0] rd_data,
  output logic [spn_pkg::BLOCK_W-1:0] block_out,
  output logic                        busy,
  output logic                        done
);

  logic [spn_pkg::BLOCK_W-1:0] state;
  logic [spn_pkg::BLOCK_W-1:0] round_key;
  logic [spn_pkg::BLOCK_W-1:0] next_state;

  spn_cfg_if cfg_if ();

  spn_regs u_regs (
    .clk      (clk),
    .rst      (rst),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .cmd_data (cmd_data),
    .rd_data  (rd_data),
    .cfg      (cfg_if.cfg)
  );

  spn_ctrl u_ctrl (
    .clk       (clk),
    .rst       (rst),
    .eng       (cfg_if.eng),
    .state     (state),
    .round_key (round_key),
    .next_state(next_state),
    .block_out (block_out),
    .busy_out  (busy),
    .done_out  (done)
  );

  spn_round u_round (
    .state     (state),
    .round_key (round_key),
    .next_state(next_state)
  );

endmodule

//--- tb/tb_clk.sv
`timescale 1ns/100ps

module tb_clk (
  output logic clk
);

  initial begin
    clk = 1'b0;
  end

  always #5 clk = ~clk; // 10 ns period.

endmodule

//--- tb/spn_properties.sv
`timescale 1ns/100ps

module spn_properties (
  input logic                        clk,
  input logic                        rst,
  input logic                        cmd_valid,
  input spn_pkg::spn_op_e            cmd_op,
  input logic [spn_pkg::BLOCK_W-1:0] cmd_data,
  input logic                        busy,
  input logic                        done
);

  logic [spn_pkg::ROUND_W-1:0] rounds_sh;  // last written round count.
  logic [spn_pkg::ROUND_W-1:0] rounds_run; // count of the current run.
  logic [4:0]                  cnt;        // edges left until done is sampled.
  logic                        accepted;
  int                          fail_count;

  initial begin
    fail_count = 0;
  end

  assign accepted = cmd_valid && (cmd_op == spn_pkg::OP_START) && !busy;

  always_ff @(posedge clk) begin
    if (rst) begin
      rounds_sh <= '0;
      rounds_run <= '0;
      cnt <= '0;
    end else begin
      if (cmd_valid && (cmd_op == spn_pkg::OP_ROUNDS)) begin
        rounds_sh <= cmd_data[spn_pkg::ROUND_W-1:0];
      end
      if (accepted) begin
        rounds_run <= rounds_sh;
        cnt <= {1'b0, rounds_sh} + 5'd2; // done in the R+2th cycle on.
      end else if (cnt != 5'd0) begin
        cnt <= cnt - 5'd1;
      end
    end
  end

  a_reset_quiet: assert property (@(posedge clk) rst |=> (!busy && !done))
    else begin
      $error("busy or done high right after reset");
      fail_count++;
    end

  // done only where the start plus R+2 cycles says.
  a_done_timing: assert property (@(posedge clk) disable iff (rst) done == (cnt == 5'd1))
    else begin
      $error("done pulse not at R+2 cycles after an accepted start");
      fail_count++;
    end

  a_done_pulse: assert property (@(posedge clk) disable iff (rst) done |=> !done)
    else begin
      $error("done held high for more than one cycle");
      fail_count++;
    end

  a_busy_window: assert property (@(posedge clk) disable iff (rst)
      busy == ((cnt > 5'd1) && (cnt < {1'b0, rounds_run} + 5'd2)))
    else begin
      $error("busy outside the window from start pulse to done");
      fail_count++;
    end

endmodule

//--- tb/spn_tb.sv
`timescale 1ns/100ps

module spn_tb;

  logic                        clk;
  logic                        rst;
  logic                        cmd_valid;
  spn_pkg::spn_op_e            cmd_op;
  logic [spn_pkg::BLOCK_W-1:0] cmd_data;
  logic [spn_pkg::BLOCK_W-1:0] rd_data;
  logic [spn_pkg::BLOCK_W-1:0] block_out;
  logic                        busy;
  logic                        done;

  int seed;
  int errors;
  int checks;

  tb_clk u_clk (
    .clk(clk)
  );

  spn_top dut (
    .clk      (clk),
    .rst      (rst),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .cmd_data (cmd_data),
    .rd_data  (rd_data),
    .block_out(block_out),
    .busy     (busy),
    .done     (done)
  );

  bind spn_top spn_properties u_props (
    .clk      (clk),
    .rst      (rst),
    .cmd_valid(cmd_valid),
    .cmd_op   (cmd_op),
    .cmd_data (cmd_data),
    .busy     (busy),
    .done     (done)
  );

  function automatic logic [spn_pkg::BLOCK_W-1:0] rand_word();
    logic [31:0] lo;
    logic [31:0] hi;
    lo = $random(seed);
    hi = $random(seed);
    return {hi[spn_pkg::BLOCK_W-33:0], lo};
  endfunction

  function automatic logic [spn_pkg::BLOCK_W-1:0] widen(input logic b);
    return {{(spn_pkg::BLOCK_W-1){1'b0}}, b};
  endfunction

  task automatic check_value(input string name, input logic [spn_pkg::BLOCK_W-1:0] expected,
                             input logic [spn_pkg::BLOCK_W-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // one command per strobe, held for a single cycle.
  task automatic send_cmd(input spn_pkg::spn_op_e op,
                          input logic [spn_pkg::BLOCK_W-1:0] data);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd_op = op;
    cmd_data = data;
    @(negedge clk);
    cmd_valid = 1'b0;
    cmd_data = '0;
  endtask

  // a fresh start on every cycle of the run, the last busy cycle included.
  task automatic start_while_busy(input string name);
    int n;
    n = 0;
    cmd_valid = 1'b1;
    cmd_op = spn_pkg::OP_START;
    while (busy && n < 40) begin
      cmd_data = rand_word();
      @(negedge clk);
      n++;
    end
    cmd_valid = 1'b0;
    cmd_data = '0;
    if (busy) begin
      $display("%s: timed out waiting for busy to fall", name);
      errors++;
    end
  endtask

  task automatic wait_done(input string name);
    int n;
    n = 0;
    while (!done && n < 40) begin
      @(negedge clk);
      n++;
    end
    if (!done) begin
      $display("%s: timed out waiting for done", name);
      errors++;
    end
  endtask

  task automatic wait_busy(input string name);
    int n;
    n = 0;
    while (!busy && n < 10) begin
      @(negedge clk);
      n++;
    end
    if (!busy) begin
      $display("%s: timed out waiting for busy", name);
      errors++;
    end
  endtask

  task automatic run_encrypt(input string name, input logic [spn_pkg::ROUND_W-1:0] r,
                             input logic [spn_pkg::BLOCK_W-1:0] k,
                             input logic [spn_pkg::BLOCK_W-1:0] p,
                             output logic [spn_pkg::BLOCK_W-1:0] res);
    send_cmd(spn_pkg::OP_KEY, k);
    send_cmd(spn_pkg::OP_ROUNDS, {{(spn_pkg::BLOCK_W-spn_pkg::ROUND_W){1'b0}}, r});
    send_cmd(spn_pkg::OP_START, p);
    wait_done(name);
    res = block_out;
  endtask

  initial begin
    logic [spn_pkg::BLOCK_W-1:0] key;
    logic [spn_pkg::BLOCK_W-1:0] pt;
    logic [spn_pkg::BLOCK_W-1:0] res_a;
    logic [spn_pkg::BLOCK_W-1:0] res_b;
    logic [spn_pkg::ROUND_W-1:0] zero_rounds [3];
    int extra_done;

    seed = 70357;
    errors = 0;
    checks = 0;
    zero_rounds = '{4'd1, 4'd7, 4'd15};
    rst = 1'b1;
    cmd_valid = 1'b0;
    cmd_op = spn_pkg::OP_KEY;
    cmd_data = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    check_value("reset_busy", '0, widen(busy));
    check_value("reset_done", '0, widen(done));
    check_value("reset_rd_data", '0, rd_data);
    check_value("reset_block_out", '0, block_out);

    key = rand_word();
    send_cmd(spn_pkg::OP_KEY, key);
    send_cmd(spn_pkg::OP_READ_KEY, '0);
    check_value("key_readback", key, rd_data);

    // no rounds, only the key addition.
    for (int i = 0; i < 3; i++) begin
      key = rand_word();
      pt = rand_word();
      run_encrypt("whitening", 4'd0, key, pt, res_a);
      check_value("whitening", pt ^ key, res_a);
    end

    foreach (zero_rounds[i]) begin
      run_encrypt("zero_fixed_point", zero_rounds[i], '0, '0, res_a);
      check_value("zero_fixed_point", '0, res_a);
    end

    // same start twice, for a spread of round counts.
    for (int r = 1; r < 16; r += 2) begin
      key = rand_word();
      pt = rand_word();
      run_encrypt("repeat_first", r[spn_pkg::ROUND_W-1:0], key, pt, res_a);
      run_encrypt("repeat_second", r[spn_pkg::ROUND_W-1:0], key, pt, res_b);
      check_value("repeat_start", res_a, res_b);
    end

    key = rand_word();
    pt = rand_word();
    send_cmd(spn_pkg::OP_KEY, key);
    send_cmd(spn_pkg::OP_ROUNDS, {{(spn_pkg::BLOCK_W-spn_pkg::ROUND_W){1'b0}}, 4'd9});
    send_cmd(spn_pkg::OP_START, pt);
    wait_busy("busy_protect");
    start_while_busy("busy_protect"); // engine busy, all must be dropped.
    wait_done("busy_protect");
    res_a = block_out;
    extra_done = 0;
    repeat (20) begin
      @(negedge clk);
      if (done) extra_done++;
    end
    checks++;
    if (extra_done != 0) begin
      $display("busy_protect: a start issued while busy produced a second done pulse");
      errors++;
    end
    check_value("busy_hold", res_a, block_out);
    run_encrypt("busy_alone", 4'd9, key, pt, res_b);
    check_value("busy_protect", res_b, res_a);

    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors,
             dut.u_props.fail_count);
    if (errors == 0 && dut.u_props.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- files.f
hw/gf_pkg.sv
hw/spn_pkg.sv
hw/spn_cfg_if.sv
hw/sbox6.sv
hw/spn_round.sv
hw/spn_regs.sv
hw/spn_ctrl.sv
hw/spn_top.sv
tb/tb_clk.sv
tb/spn_properties.sv
tb/spn_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module spn_tb -f files.f

run: compile
	-./obj_dir/Vspn_tb > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir $(LOG)
